//--- Makefile
TOP := tb_offload_hub

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timescale 1ns/10ps --top-module offload_hub \
	  hw/offload_pkg.sv hw/offload_decode.sv hw/ssr_cfg_unit.sv \
	  hw/offload_arbiter.sv hw/offload_hub.sv

obj_dir/V$(TOP): filelist.f hw/*.sv dv/*.sv
	verilator --binary --timing --assert --timescale 1ns/10ps \
	  --top-module $(TOP) -f filelist.f -o V$(TOP)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	grep -q "^TEST OK$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- dv/tb_clk_gen.sv
// ------------------------------
// Testbench clock and reset source
// 4 ns clock, reset held low for the first 10 cycles
// ------------------------------
`timescale 1ns/10ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // Release lines up with the stimulus offset after an edge
  initial begin
    rst_no = 1'b0;
    repeat (10) @(posedge clk_o);
    #1 rst_no = 1'b1;
  end

endmodule

//--- dv/tb_offload_hub.sv
// ------------------------------
// Testbench of the offload hub
// Applies a request table, stubs the four accelerators and
// matches every core response against a scoreboard
// ------------------------------
`timescale 1ns/10ps

module tb_offload_hub;

  localparam int Timeout = 200;
  localparam int NumRows = 25;

  typedef struct packed {
    logic [2:0]  tgt;
    logic [4:0]  id;
    logic [31:0] op;
    logic [31:0] arga;
    logic [31:0] argb;
    logic [4:0]  exp_id;
    logic [31:0] exp_data;
    logic        exp_err;
    logic [7:0]  rdy;
  } row_t;

  logic            clk;
  logic            rst_n;
  logic            acc_qvalid_i, acc_qready_o, acc_pvalid_o, acc_pready_i, acc_perror_o;
  logic [2:0]      acc_qtarget_i;
  logic [4:0]      acc_qid_i, acc_pid_o, ext_qid_o;
  logic [31:0]     acc_qop_i, acc_qarga_i, acc_qargb_i, acc_pdata_o;
  logic [31:0]     ext_qop_o, ext_qarga_o, ext_qargb_o;
  logic [3:0]      ext_qvalid_o, ext_qready_i, ext_pvalid_i, ext_pready_o, ext_perror_i;
  logic [3:0][4:0] ext_pid_i;
  logic [3:0][31:0] ext_pdata_i;

  logic [7:0]      rdy_pat;
  logic [37:0]     exp_q [$];
  logic [31:0]     ssr_model [3][8];
  logic [36:0]     stub_mem [4][64];
  logic [5:0]      stub_wr [4];
  logic [5:0]      stub_rd [4];
  int              errors;
  int              timeouts;

  // Rdy gives the core ready pattern of a row or 0 for random ready
  row_t rows [NumRows] = '{
    '{3'd0, 5'd1,  32'h0000_0053, 32'h0000_00a5, 32'h1111_0000, 5'd1,  32'h0000_00a5, 1'b0, 8'hff},
    '{3'd1, 5'd2,  32'h0200_0033, 32'h1234_5678, 32'h0000_0005, 5'd2,  32'h1234_4678, 1'b0, 8'hff},
    '{3'd2, 5'd3,  32'h0000_002b, 32'hdead_beef, 32'h0000_0000, 5'd3,  32'hdead_9eef, 1'b0, 8'haa},
    '{3'd3, 5'd4,  32'h0000_000b, 32'h0000_3000, 32'h0000_0007, 5'd4,  32'h0000_0000, 1'b0, 8'h55},
    '{3'd4, 5'd5,  32'h0410_202b, 32'hcafe_0001, 32'h0000_0000, 5'd0,  32'h0000_0000, 1'b0, 8'hff},
    '{3'd4, 5'd6,  32'h0410_102b, 32'h0000_0000, 32'h0000_0000, 5'd6,  32'hcafe_0001, 1'b0, 8'hff},
    '{3'd4, 5'd7,  32'h0000_602b, 32'h0bad_f00d, 32'h0000_0041, 5'd0,  32'hcafe_0001, 1'b0, 8'hcc},
    '{3'd4, 5'd8,  32'h0410_102b, 32'h0000_0000, 32'h0000_0000, 5'd8,  32'h0bad_f00d, 1'b0, 8'hff},
    '{3'd4, 5'd9,  32'h0000_502b, 32'h0000_0000, 32'h0000_0041, 5'd9,  32'h0bad_f00d, 1'b0, 8'h0f},
    '{3'd4, 5'd10, 32'h0450_202b, 32'hffff_ffff, 32'h0000_0000, 5'd0,  32'h0000_0000, 1'b0, 8'hff},
    '{3'd4, 5'd11, 32'h0450_102b, 32'h0000_0000, 32'h0000_0000, 5'd11, 32'h0000_0000, 1'b0, 8'hff},
    '{3'd4, 5'd12, 32'h0000_502b, 32'h0000_0000, 32'h0000_0141, 5'd12, 32'h0000_0000, 1'b0, 8'hff},
    '{3'd4, 5'd13, 32'h0000_302b, 32'h0000_0001, 32'h0000_0000, 5'd13, 32'h0000_0000, 1'b1, 8'hff},
    '{3'd4, 5'd14, 32'h0000_0033, 32'h0000_0000, 32'h0000_0000, 5'd14, 32'h0000_0000, 1'b1, 8'hff},
    '{3'd5, 5'd15, 32'h0410_102b, 32'h0000_0000, 32'h0000_0000, 5'd15, 32'h0000_0000, 1'b1, 8'hff},
    '{3'd6, 5'd16, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 5'd16, 32'h0000_0000, 1'b1, 8'hff},
    '{3'd7, 5'd17, 32'h0410_202b, 32'h0000_0001, 32'h0000_0000, 5'd17, 32'h0000_0000, 1'b1, 8'hff},
    '{3'd0, 5'd18, 32'h0000_0053, 32'h0000_0018, 32'h0000_0000, 5'd18, 32'h0000_0018, 1'b0, 8'h00},
    '{3'd4, 5'd19, 32'h0410_202b, 32'h5555_aaaa, 32'h0000_0000, 5'd0,  32'h0bad_f00d, 1'b0, 8'h00},
    '{3'd1, 5'd20, 32'h0200_0033, 32'h0000_1234, 32'h0000_0000, 5'd20, 32'h0000_0234, 1'b0, 8'h00},
    '{3'd4, 5'd21, 32'h0000_502b, 32'h0000_0000, 32'h0000_0041, 5'd21, 32'h5555_aaaa, 1'b0, 8'h00},
    '{3'd2, 5'd22, 32'h0000_0013, 32'h0000_2222, 32'h0000_0000, 5'd22, 32'h0000_0222, 1'b0, 8'h00},
    '{3'd3, 5'd23, 32'h0000_000b, 32'h0000_0003, 32'h0000_0000, 5'd23, 32'h0000_3003, 1'b0, 8'h00},
    '{3'd4, 5'd24, 32'h0e20_202b, 32'h7777_0000, 32'h0000_0000, 5'd0,  32'h0000_0000, 1'b0, 8'h00},
    '{3'd4, 5'd25, 32'h0e20_102b, 32'h0000_0000, 32'h0000_0000, 5'd25, 32'h7777_0000, 1'b0, 8'h00}
  };

  tb_clk_gen i_tb_clk_gen (.clk_o(clk), .rst_no(rst_n));

  offload_hub i_offload_hub (.clk_i(clk), .rst_ni(rst_n), .*);

  task automatic report_mismatch(input string name, input logic [127:0] got,
                                 input logic [127:0] exp);
    errors++;
    $display("ERR %0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
  endtask

  // SSR word model built from the configuration rules of the hub
  task automatic predict_ssr(input row_t r, output logic [37:0] pred);
    logic [2:0]  f3;
    logic [11:0] addr;
    logic        legal;
    logic        in_rng;
    logic [31:0] old;
    f3     = r.op[14:12];
    legal  = (r.tgt == 3'd4) && (r.op[6:0] == offload_pkg::SsrCfgOpcode);
    // Register forms have funct3 bit 2 set
    addr   = f3[2] ? r.argb[11:0] : r.op[31:20];
    in_rng = (addr[4:0] < 5'(offload_pkg::NumSsrs)) && (addr[11:5] < 7'(offload_pkg::NumCfgRegs));
    old    = in_rng ? ssr_model[addr[1:0]][addr[7:5]] : 32'h0;
    if (legal && (f3 == offload_pkg::OpScfgwi || f3 == offload_pkg::OpScfgw)) begin
      pred = {5'd0, old, 1'b0};
      if (in_rng) begin
        ssr_model[addr[1:0]][addr[7:5]] = r.arga;
      end
    end else if (legal && (f3 == offload_pkg::OpScfgri || f3 == offload_pkg::OpScfgr)) begin
      pred = {r.id, old, 1'b0};
    end else begin
      pred = {r.id, 32'h0, 1'b1};
    end
  endtask

  // Holds the request until accepted and checks the steering each cycle
  task automatic issue_request(input row_t r, output logic ok);
    int         cyc;
    logic [3:0] exp_v;
    exp_v         = (r.tgt < 3'd4) ? (4'b0001 << r.tgt[1:0]) : 4'b0000;
    acc_qvalid_i  = 1'b1;
    acc_qtarget_i = r.tgt;
    acc_qid_i     = r.id;
    acc_qop_i     = r.op;
    acc_qarga_i   = r.arga;
    acc_qargb_i   = r.argb;
    rdy_pat       = r.rdy;
    cyc = 0;
    ok  = 1'b0;
    while (!ok && cyc < Timeout) begin
      @(posedge clk);
      cyc++;
      assert (ext_qvalid_o == exp_v)
        else report_mismatch("ext_qvalid_o", 128'(ext_qvalid_o), 128'(exp_v));
      if (exp_v != 4'b0000) begin
        assert ({ext_qid_o, ext_qop_o, ext_qarga_o, ext_qargb_o} == {r.id, r.op, r.arga, r.argb})
          else report_mismatch("ext_qid_o/ext_qop_o/ext_qarga_o/ext_qargb_o",
                               128'({ext_qid_o, ext_qop_o, ext_qarga_o, ext_qargb_o}),
                               128'({r.id, r.op, r.arga, r.argb}));
      end
      if (acc_qready_o) begin
        exp_q.push_back({r.exp_id, r.exp_data, r.exp_err});
        ok = 1'b1;
      end
    end
    #1;
    acc_qvalid_i = 1'b0;
  endtask

  // Write responses share id 0 and also match on old data
  task automatic match_response(input logic [4:0] id, input logic [31:0] data, input logic err);
    int idx;
    idx = -1;
    for (int i = 0; i < exp_q.size(); i++) begin
      if (idx < 0 && exp_q[i][37:33] == id && (id != 5'd0 || exp_q[i][32:1] == data)) begin
        idx = i;
      end
    end
    assert (idx >= 0) else begin
      errors++;
      $display("%0t: response id %0d data 0x%h matches no pending request", $time, id, data);
    end
    if (idx >= 0) begin
      assert (exp_q[idx] == {id, data, err})
        else report_mismatch("acc_pdata_o/acc_perror_o", 128'({data, err}), 128'(exp_q[idx][32:0]));
      exp_q.delete(idx);
    end
  endtask

  // ------------------------------
  // Accelerator stubs
  // ------------------------------
  initial begin
    ext_qready_i = '0;
    ext_pvalid_i = '0;
    ext_pid_i    = '0;
    ext_pdata_i  = '0;
    ext_perror_i = '0;
    for (int p = 0; p < 4; p++) begin
      stub_wr[p] = '0;
      stub_rd[p] = '0;
    end
    forever begin
      @(posedge clk);
      for (int p = 0; p < 4; p++) begin
        if (ext_qvalid_o[p] && ext_qready_i[p]) begin
          stub_mem[p][stub_wr[p]] = {ext_qid_o, ext_qarga_o ^ (32'(p) << 12)};
          stub_wr[p] = stub_wr[p] + 6'd1;
        end
        if (ext_pvalid_i[p] && ext_pready_o[p]) begin
          stub_rd[p] = stub_rd[p] + 6'd1;
        end
      end
      #1;
      for (int p = 0; p < 4; p++) begin
        ext_qready_i[p] = 1'($urandom);
        ext_pvalid_i[p] = (stub_wr[p] != stub_rd[p]);
        {ext_pid_i[p], ext_pdata_i[p]} = stub_mem[p][stub_rd[p]];
      end
    end
  end

  // Core response ready
  initial begin
    logic [2:0] rdy_cyc;
    rdy_cyc      = '0;
    acc_pready_i = 1'b0;
    forever begin
      @(posedge clk);
      rdy_cyc = rdy_cyc + 3'd1;
      #1;
      acc_pready_i = (rdy_pat == 8'h00) ? 1'($urandom) : rdy_pat[rdy_cyc];
    end
  end

  // Response monitor
  initial begin
    logic        held;
    logic [37:0] held_rsp;
    held     = 1'b0;
    held_rsp = '0;
    forever begin
      @(posedge clk);
      if (!rst_n) begin
        held = 1'b0;
      end else begin
        if (held) begin
          assert ({acc_pvalid_o, acc_pid_o, acc_pdata_o, acc_perror_o} == {1'b1, held_rsp})
            else report_mismatch("acc_pvalid_o/acc_pid_o/acc_pdata_o/acc_perror_o held",
                                 128'({acc_pvalid_o, acc_pid_o, acc_pdata_o, acc_perror_o}),
                                 128'({1'b1, held_rsp}));
        end
        if (acc_pvalid_o && acc_pready_i) begin
          match_response(acc_pid_o, acc_pdata_o, acc_perror_o);
        end
        held     = acc_pvalid_o && !acc_pready_i;
        held_rsp = {acc_pid_o, acc_pdata_o, acc_perror_o};
      end
    end
  end

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    logic [37:0] pred;
    logic        ok;
    int          cyc;
    void'($urandom(32'h8559_7896));
    errors        = 0;
    timeouts      = 0;
    rdy_pat       = 8'hff;
    acc_qvalid_i  = 1'b0;
    acc_qtarget_i = '0;
    acc_qid_i     = '0;
    acc_qop_i     = '0;
    acc_qarga_i   = '0;
    acc_qargb_i   = '0;
    ssr_model     = '{default: '0};
    cyc = 0;
    while (!rst_n && cyc < Timeout) begin
      @(posedge clk);
      cyc++;
    end
    ok = rst_n;
    if (!ok) begin
      timeouts++;
      $display("Timeout: reset was never released");
    end else begin
      assert (!acc_pvalid_o) else report_mismatch("acc_pvalid_o", 128'(acc_pvalid_o), 128'(0));
      assert (ext_qvalid_o == 4'b0000)
        else report_mismatch("ext_qvalid_o", 128'(ext_qvalid_o), 128'(0));
      #1;
      for (int n = 0; n < NumRows; n++) begin
        if (rows[n].tgt >= 3'd4) begin
          predict_ssr(rows[n], pred);
          assert (pred == {rows[n].exp_id, rows[n].exp_data, rows[n].exp_err}) else begin
            errors++;
            $display("Row %0d expects a result that the SSR model does not predict", n);
          end
        end
        issue_request(rows[n], ok);
        if (!ok) begin
          timeouts++;
          $display("Timeout: request of row %0d was never accepted", n);
          break;
        end
      end
    end
    if (ok) begin
      rdy_pat = 8'hff;
      cyc = 0;
      while (exp_q.size() != 0 && cyc < Timeout) begin
        @(posedge clk);
        #1;
        cyc++;
      end
      if (exp_q.size() != 0) begin
        timeouts++;
        $display("Timeout: %0d responses never arrived", exp_q.size());
      end
      // Nothing may follow the last expected response
      repeat (4) begin
        @(posedge clk);
        assert (!acc_pvalid_o) else report_mismatch("acc_pvalid_o", 128'(acc_pvalid_o), 128'(0));
      end
    end
    $display("Errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- filelist.f
hw/offload_pkg.sv
hw/offload_decode.sv
hw/ssr_cfg_unit.sv
hw/offload_arbiter.sv
hw/offload_hub.sv
dv/tb_clk_gen.sv
dv/tb_offload_hub.sv

//--- hw/offload_arbiter.sv
// ------------------------------
// Round-robin response arbiter
// Merges the accelerator and SSR response streams into one
// stream toward the core, holding the grant while it stalls
// ------------------------------
`timescale 1ns/10ps

module offload_arbiter (
  input  logic                                                       clk_i,
  input  logic                                                       rst_ni,
  input  logic [offload_pkg::NumRsp-1:0]                             inp_valid_i,
  output logic [offload_pkg::NumRsp-1:0]                             inp_ready_o,
  input  logic [offload_pkg::NumRsp-1:0][offload_pkg::IdWidth-1:0]   inp_id_i,
  input  logic [offload_pkg::NumRsp-1:0][offload_pkg::DataWidth-1:0] inp_data_i,
  input  logic [offload_pkg::NumRsp-1:0]                             inp_error_i,
  output logic                                                       oup_valid_o,
  input  logic                                                       oup_ready_i,
  output logic [offload_pkg::IdWidth-1:0]                            oup_id_o,
  output logic [offload_pkg::DataWidth-1:0]                          oup_data_o,
  output logic                                                       oup_error_o
);

  logic [offload_pkg::RspIdxWidth-1:0] rr_q;
  logic [offload_pkg::RspIdxWidth-1:0] gnt_q;
  logic                                lock_q;
  logic [offload_pkg::RspIdxWidth-1:0] gnt_idx;
  logic                                stall;

  // ------------------------------
  // Grant selection
  // ------------------------------
  always_comb begin
    int unsigned cand;
    logic        found;
    gnt_idx = rr_q;
    found   = 1'b0;
    // Scan starting at the pointer, wrapping around once
    for (int unsigned i = 0; i < offload_pkg::NumRsp; i++) begin
      cand = int'(rr_q) + i;
      if (cand >= offload_pkg::NumRsp) begin
        cand = cand - offload_pkg::NumRsp;
      end
      if (!found && inp_valid_i[cand]) begin
        gnt_idx = offload_pkg::RspIdxWidth'(cand);
        found   = 1'b1;
      end
    end
    // Stalled output keeps the earlier winner
    if (lock_q) begin
      gnt_idx = gnt_q;
    end
  end

  assign oup_valid_o = inp_valid_i[gnt_idx];
  assign oup_id_o    = inp_id_i[gnt_idx];
  assign oup_data_o  = inp_data_i[gnt_idx];
  assign oup_error_o = inp_error_i[gnt_idx];
  assign stall       = oup_valid_o & ~oup_ready_i;

  always_comb begin
    inp_ready_o          = '0;
    inp_ready_o[gnt_idx] = oup_valid_o & oup_ready_i;
  end

  // ------------------------------
  // Pointer and lock
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q   <= '0;
      gnt_q  <= '0;
      lock_q <= 1'b0;
    end else begin
      lock_q <= stall;
      if (stall) begin
        gnt_q <= gnt_idx;
      end
      // Winner gets lowest priority next round
      if (oup_valid_o && oup_ready_i) begin
        if (gnt_idx == offload_pkg::RspIdxWidth'(offload_pkg::NumRsp - 1)) begin
          rr_q <= '0;
        end else begin
          rr_q <= gnt_idx + 1'b1;
        end
      end
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(inp_ready_o))
    else $error("offload_arbiter: more than one source granted");

endmodule

//--- hw/offload_decode.sv
// ------------------------------
// Offload decode stage, purely combinational
// Steers a core request to one accelerator port or the SSR unit
// and forms the SSR configuration address and kind
// ------------------------------
`timescale 1ns/10ps

module offload_decode (
  input  logic                                    acc_qvalid_i,
  input  offload_pkg::target_e                    acc_qtarget_i,
  input  logic [offload_pkg::DataWidth-1:0]       acc_qop_i,
  input  logic [offload_pkg::DataWidth-1:0]       acc_qargb_i,
  output logic                                    acc_qready_o,
  output logic [offload_pkg::NumExt-1:0]          ext_qvalid_o,
  input  logic [offload_pkg::NumExt-1:0]          ext_qready_i,
  output logic                                    cfg_valid_o,
  input  logic                                    cfg_ready_i,
  output offload_pkg::cfg_kind_e                  cfg_kind_o,
  output logic [offload_pkg::SsrIdxWidth-1:0]     cfg_ssr_o,
  output logic [offload_pkg::RegIdxWidth-1:0]     cfg_reg_o
);

  offload_pkg::ssr_op_e                   ssr_op;
  logic                                   is_cfg_opcode;
  logic [offload_pkg::CfgAddrWidth-1:0]   cfg_addr;

  // ------------------------------
  // Target steering
  // ------------------------------
  always_comb begin
    ext_qvalid_o = '0;
    cfg_valid_o  = 1'b0;
    acc_qready_o = 1'b0;
    case (acc_qtarget_i)
      offload_pkg::TgtFpu,
      offload_pkg::TgtMulDiv,
      offload_pkg::TgtDma,
      offload_pkg::TgtIpu: begin
        ext_qvalid_o[acc_qtarget_i[1:0]] = acc_qvalid_i;
        acc_qready_o = ext_qready_i[acc_qtarget_i[1:0]];
      end
      // SSR unit, also absorbs the unused targets as illegal
      default: begin
        cfg_valid_o  = acc_qvalid_i;
        acc_qready_o = cfg_ready_i;
      end
    endcase
  end

  // ------------------------------
  // SSR instruction decode
  // ------------------------------
  assign ssr_op        = offload_pkg::ssr_op_e'(acc_qop_i[14:12]);
  assign is_cfg_opcode = (acc_qtarget_i == offload_pkg::TgtSsr) &&
                         (acc_qop_i[6:0] == offload_pkg::SsrCfgOpcode);

  always_comb begin
    cfg_kind_o = offload_pkg::KindIllegal;
    // Immediate forms carry the address in the I-type immediate
    cfg_addr   = acc_qop_i[31:20];
    if (is_cfg_opcode) begin
      case (ssr_op)
        offload_pkg::OpScfgri: cfg_kind_o = offload_pkg::KindRead;
        offload_pkg::OpScfgwi: cfg_kind_o = offload_pkg::KindWrite;
        offload_pkg::OpScfgr: begin
          cfg_kind_o = offload_pkg::KindRead;
          cfg_addr   = acc_qargb_i[offload_pkg::CfgAddrWidth-1:0];
        end
        offload_pkg::OpScfgw: begin
          cfg_kind_o = offload_pkg::KindWrite;
          cfg_addr   = acc_qargb_i[offload_pkg::CfgAddrWidth-1:0];
        end
        default: cfg_kind_o = offload_pkg::KindIllegal;
      endcase
    end
  end

  // Low bits select the SSR, high bits the register within it
  assign cfg_ssr_o = cfg_addr[offload_pkg::SsrIdxWidth-1:0];
  assign cfg_reg_o = cfg_addr[offload_pkg::CfgAddrWidth-1:offload_pkg::SsrIdxWidth];

  // A request never fans out to two destinations
  always_comb begin
    assert ($onehot0({cfg_valid_o, ext_qvalid_o}))
      else $error("offload_decode: more than one destination valid");
  end

endmodule

//--- hw/offload_hub.sv
// ------------------------------
// Accelerator offload hub, top level
// Core request in, four accelerator ports and the local SSR
// configuration unit out, responses merged back to the core
// ------------------------------
`timescale 1ns/10ps

module offload_hub (
  input  logic                                                       clk_i,
  input  logic                                                       rst_ni,
  // Core request
  input  logic                                                       acc_qvalid_i,
  output logic                                                       acc_qready_o,
  input  logic [offload_pkg::TargetWidth-1:0]                        acc_qtarget_i,
  input  logic [offload_pkg::IdWidth-1:0]                            acc_qid_i,
  input  logic [offload_pkg::DataWidth-1:0]                          acc_qop_i,
  input  logic [offload_pkg::DataWidth-1:0]                          acc_qarga_i,
  input  logic [offload_pkg::DataWidth-1:0]                          acc_qargb_i,
  // Core response
  output logic                                                       acc_pvalid_o,
  input  logic                                                       acc_pready_i,
  output logic [offload_pkg::IdWidth-1:0]                            acc_pid_o,
  output logic [offload_pkg::DataWidth-1:0]                          acc_pdata_o,
  output logic                                                       acc_perror_o,
  // Accelerator requests, payload shared by all ports
  output logic [offload_pkg::NumExt-1:0]                             ext_qvalid_o,
  input  logic [offload_pkg::NumExt-1:0]                             ext_qready_i,
  output logic [offload_pkg::IdWidth-1:0]                            ext_qid_o,
  output logic [offload_pkg::DataWidth-1:0]                          ext_qop_o,
  output logic [offload_pkg::DataWidth-1:0]                          ext_qarga_o,
  output logic [offload_pkg::DataWidth-1:0]                          ext_qargb_o,
  // Accelerator responses
  input  logic [offload_pkg::NumExt-1:0]                             ext_pvalid_i,
  output logic [offload_pkg::NumExt-1:0]                             ext_pready_o,
  input  logic [offload_pkg::NumExt-1:0][offload_pkg::IdWidth-1:0]   ext_pid_i,
  input  logic [offload_pkg::NumExt-1:0][offload_pkg::DataWidth-1:0] ext_pdata_i,
  input  logic [offload_pkg::NumExt-1:0]                             ext_perror_i
);

  // Decode to SSR unit
  logic                                cfg_valid;
  logic                                cfg_ready;
  offload_pkg::cfg_kind_e              cfg_kind;
  logic [offload_pkg::SsrIdxWidth-1:0] cfg_ssr;
  logic [offload_pkg::RegIdxWidth-1:0] cfg_reg;

  // SSR unit response
  logic                                ssr_pvalid;
  logic                                ssr_pready;
  logic [offload_pkg::IdWidth-1:0]     ssr_pid;
  logic [offload_pkg::DataWidth-1:0]   ssr_pdata;
  logic                                ssr_perror;

  logic [offload_pkg::NumRsp-1:0]      rsp_ready;

  // Payload is broadcast, only the valid line selects the port
  assign ext_qid_o   = acc_qid_i;
  assign ext_qop_o   = acc_qop_i;
  assign ext_qarga_o = acc_qarga_i;
  assign ext_qargb_o = acc_qargb_i;

  offload_decode i_offload_decode (
    .acc_qvalid_i  (acc_qvalid_i),
    .acc_qtarget_i (offload_pkg::target_e'(acc_qtarget_i)),
    .acc_qop_i     (acc_qop_i),
    .acc_qargb_i   (acc_qargb_i),
    .acc_qready_o  (acc_qready_o),
    .ext_qvalid_o  (ext_qvalid_o),
    .ext_qready_i  (ext_qready_i),
    .cfg_valid_o   (cfg_valid),
    .cfg_ready_i   (cfg_ready),
    .cfg_kind_o    (cfg_kind),
    .cfg_ssr_o     (cfg_ssr),
    .cfg_reg_o     (cfg_reg)
  );

  ssr_cfg_unit i_ssr_cfg_unit (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cfg_valid_i (cfg_valid),
    .cfg_ready_o (cfg_ready),
    .cfg_kind_i  (cfg_kind),
    .cfg_ssr_i   (cfg_ssr),
    .cfg_reg_i   (cfg_reg),
    .cfg_id_i    (acc_qid_i),
    .cfg_wdata_i (acc_qarga_i),
    .rsp_valid_o (ssr_pvalid),
    .rsp_ready_i (ssr_pready),
    .rsp_id_o    (ssr_pid),
    .rsp_data_o  (ssr_pdata),
    .rsp_error_o (ssr_perror)
  );

  // SSR unit sits at the top index, above the four accelerators
  offload_arbiter i_offload_arbiter (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .inp_valid_i ({ssr_pvalid, ext_pvalid_i}),
    .inp_ready_o (rsp_ready),
    .inp_id_i    ({ssr_pid, ext_pid_i}),
    .inp_data_i  ({ssr_pdata, ext_pdata_i}),
    .inp_error_i ({ssr_perror, ext_perror_i}),
    .oup_valid_o (acc_pvalid_o),
    .oup_ready_i (acc_pready_i),
    .oup_id_o    (acc_pid_o),
    .oup_data_o  (acc_pdata_o),
    .oup_error_o (acc_perror_o)
  );

  assign ext_pready_o = rsp_ready[offload_pkg::NumExt-1:0];
  assign ssr_pready   = rsp_ready[offload_pkg::NumRsp-1];

endmodule

//--- hw/offload_pkg.sv
// ------------------------------
// Shared constants and types of the accelerator offload hub
// Referenced by scoped names from every RTL stage
// ------------------------------
package offload_pkg;

  // Port counts and widths
  localparam int unsigned NumExt      = 4;
  localparam int unsigned NumRsp      = 5;
  localparam int unsigned IdWidth     = 5;
  localparam int unsigned DataWidth   = 32;
  localparam int unsigned TargetWidth = 3;
  localparam int unsigned RspIdxWidth = $clog2(NumRsp);

  // SSR configuration space
  localparam int unsigned NumSsrs      = 3;
  localparam int unsigned NumCfgRegs   = 8;
  localparam int unsigned SsrIdxWidth  = 5;
  localparam int unsigned RegIdxWidth  = 7;
  localparam int unsigned CfgAddrWidth = SsrIdxWidth + RegIdxWidth;
  localparam int unsigned SsrSelWidth  = $clog2(NumSsrs);
  localparam int unsigned RegSelWidth  = $clog2(NumCfgRegs);

  // Major opcode shared by all SSR configuration instructions
  localparam logic [6:0] SsrCfgOpcode = 7'h2b;

  // Request target field, 5 to 7 unused
  typedef enum logic [TargetWidth-1:0] {
    TgtFpu    = 3'd0,
    TgtMulDiv = 3'd1,
    TgtDma    = 3'd2,
    TgtIpu    = 3'd3,
    TgtSsr    = 3'd4
  } target_e;

  // funct3 of the SSR configuration instructions
  typedef enum logic [2:0] {
    OpScfgri = 3'd1,
    OpScfgwi = 3'd2,
    OpScfgr  = 3'd5,
    OpScfgw  = 3'd6
  } ssr_op_e;

  // Request kind seen by the configuration unit
  typedef enum logic [1:0] {
    KindRead    = 2'd0,
    KindWrite   = 2'd1,
    KindIllegal = 2'd2
  } cfg_kind_e;

endpackage

//--- hw/ssr_cfg_unit.sv
// ------------------------------
// SSR configuration unit
// Holds the configuration words of all SSRs and answers reads
// and writes through a one-entry response buffer
// ------------------------------
`timescale 1ns/10ps

module ssr_cfg_unit (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  cfg_valid_i,
  output logic                                  cfg_ready_o,
  input  offload_pkg::cfg_kind_e                cfg_kind_i,
  input  logic [offload_pkg::SsrIdxWidth-1:0]   cfg_ssr_i,
  input  logic [offload_pkg::RegIdxWidth-1:0]   cfg_reg_i,
  input  logic [offload_pkg::IdWidth-1:0]       cfg_id_i,
  input  logic [offload_pkg::DataWidth-1:0]     cfg_wdata_i,
  output logic                                  rsp_valid_o,
  input  logic                                  rsp_ready_i,
  output logic [offload_pkg::IdWidth-1:0]       rsp_id_o,
  output logic [offload_pkg::DataWidth-1:0]     rsp_data_o,
  output logic                                  rsp_error_o
);

  logic [offload_pkg::DataWidth-1:0] cfg_q [offload_pkg::NumSsrs][offload_pkg::NumCfgRegs];

  logic [offload_pkg::SsrSelWidth-1:0] ssr_sel;
  logic [offload_pkg::RegSelWidth-1:0] reg_sel;
  logic                                in_range;
  logic                                accept;
  logic                                cfg_we;
  logic [offload_pkg::DataWidth-1:0]   old_data;

  logic                                rsp_valid_q;
  logic [offload_pkg::IdWidth-1:0]     rsp_id_q;
  logic [offload_pkg::DataWidth-1:0]   rsp_data_q;
  logic                                rsp_error_q;

  // ------------------------------
  // Word lookup
  // ------------------------------
  assign in_range =
      (cfg_ssr_i < offload_pkg::SsrIdxWidth'(offload_pkg::NumSsrs)) &&
      (cfg_reg_i < offload_pkg::RegIdxWidth'(offload_pkg::NumCfgRegs));
  assign ssr_sel  = cfg_ssr_i[offload_pkg::SsrSelWidth-1:0];
  assign reg_sel  = cfg_reg_i[offload_pkg::RegSelWidth-1:0];

  // Value before the operation, 0 outside the implemented space
  assign old_data = in_range ? cfg_q[ssr_sel][reg_sel] : '0;

  // Buffer frees up when empty or draining this cycle
  assign cfg_ready_o = ~rsp_valid_q | rsp_ready_i;
  assign accept      = cfg_valid_i & cfg_ready_o;
  assign cfg_we      = accept & in_range & (cfg_kind_i == offload_pkg::KindWrite);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_q <= '{default: '0};
    end else if (cfg_we) begin
      cfg_q[ssr_sel][reg_sel] <= cfg_wdata_i;
    end
  end

  // ------------------------------
  // Response buffer
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_q <= 1'b0;
    end else if (cfg_ready_o) begin
      rsp_valid_q <= cfg_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      case (cfg_kind_i)
        // Id 0 suppresses the register write-back in the core
        offload_pkg::KindWrite: begin
          rsp_id_q    <= '0;
          rsp_data_q  <= old_data;
          rsp_error_q <= 1'b0;
        end
        offload_pkg::KindRead: begin
          rsp_id_q    <= cfg_id_i;
          rsp_data_q  <= old_data;
          rsp_error_q <= 1'b0;
        end
        default: begin
          rsp_id_q    <= cfg_id_i;
          rsp_data_q  <= '0;
          rsp_error_q <= 1'b1;
        end
      endcase
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_id_o    = rsp_id_q;
  assign rsp_data_o  = rsp_data_q;
  assign rsp_error_o = rsp_error_q;

  // A stalled response keeps its valid and its payload
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_o && !rsp_ready_i |=>
      rsp_valid_o && $stable({rsp_id_o, rsp_data_o, rsp_error_o}))
    else $error("ssr_cfg_unit: response changed while stalled");

endmodule
